// ==== rtl/core_complex_pkg.sv ====
`default_nettype none

package core_complex_pkg;

  // link field widths
  localparam int mc_addr_width_p = 4;
  localparam int mc_data_width_p = 32;
  localparam int mc_src_width_p  = 4;
  localparam int mc_reg_width_p  = 5;

  typedef enum logic [0:0] {
    mc_op_load  = 1'b0,
    mc_op_store = 1'b1
  } mc_op_e;

  // load side view of the forward payload word
  typedef struct packed {
    logic [mc_reg_width_p-1:0]                 reg_id;
    logic [mc_data_width_p-mc_reg_width_p-1:0] unused;
  } mc_load_info_s;

  // payload word whose meaning depends on op
  typedef union packed {
    logic [mc_data_width_p-1:0] store_data;
    mc_load_info_s              load_info;
  } mc_fwd_payload_u;

  // forward request of 41 bits
  typedef struct packed {
    mc_op_e                     op;
    logic [mc_addr_width_p-1:0] addr;
    logic [mc_src_width_p-1:0]  src_id;
    mc_fwd_payload_u            payload;
  } mc_fwd_packet_s;

  // return packet of 42 bits
  typedef struct packed {
    mc_op_e                     op;
    logic [mc_reg_width_p-1:0]  reg_id;
    logic [mc_src_width_p-1:0]  dest_id;
    logic [mc_data_width_p-1:0] data;
  } mc_rev_packet_s;

  // flat link widths for the chip level ports
  localparam int mc_fwd_width_p = $bits(mc_fwd_packet_s);
  localparam int mc_rev_width_p = $bits(mc_rev_packet_s);

endpackage

`default_nettype wire

// ==== rtl/mc_link_token_rx.sv ====
`default_nettype none

module mc_link_token_rx
  import core_complex_pkg::*;
 #(parameter int els_p = 4
  )
  (input  wire                  mc_clk_i
  ,input  wire                  rst_n_i

  ,input  wire                  link_v_i
  ,input  wire mc_fwd_packet_s  link_data_i
  ,output logic                 link_token_o

  ,output logic                 req_v_o
  ,output mc_fwd_packet_s       req_pkt_o
  ,input  wire                  req_yumi_i
  );

  localparam int ptr_width_lp = (els_p > 1) ? $clog2(els_p) : 1;
  localparam int cnt_width_lp = $clog2(els_p + 1);

  mc_fwd_packet_s            fifo_mem_r [els_p];
  logic [ptr_width_lp-1:0]   wr_ptr_r;
  logic [ptr_width_lp-1:0]   rd_ptr_r;
  logic [cnt_width_lp-1:0]   count_r;

  logic enq;
  logic deq;

  // upstream credits guarantee room so every valid is taken
  assign enq = link_v_i;
  assign deq = req_yumi_i & req_v_o;

  assign req_v_o   = (count_r != '0);
  assign req_pkt_o = fifo_mem_r[rd_ptr_r];

  // fifo storage
  always_ff @(posedge mc_clk_i) begin
    if (enq) begin
      fifo_mem_r[wr_ptr_r] <= link_data_i;
    end
  end

  always_ff @(posedge mc_clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (enq) begin
        wr_ptr_r <= (wr_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      end
      if (deq) begin
        rd_ptr_r <= (rd_ptr_r == ptr_width_lp'(els_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      end
      case ({enq, deq})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // one token per freed slot a cycle after the dequeue
  always_ff @(posedge mc_clk_i) begin
    if (!rst_n_i) begin
      link_token_o <= 1'b0;
    end else begin
      link_token_o <= deq;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mc_link_token_tx.sv ====
`default_nettype none

module mc_link_token_tx
  import core_complex_pkg::*;
 #(parameter int credits_p = 3
  )
  (input  wire                  mc_clk_i
  ,input  wire                  rst_n_i

  ,input  wire                  rsp_v_i
  ,input  wire mc_rev_packet_s  rsp_pkt_i
  ,output logic                 rsp_ready_o

  ,output logic                 link_v_o
  ,output mc_rev_packet_s       link_data_o
  ,input  wire                  link_token_i
  );

  localparam int cnt_width_lp = $clog2(credits_p + 1);

  logic [cnt_width_lp-1:0] credit_r;
  logic                    send;

  // never offer a transfer without a credit in hand
  assign rsp_ready_o = (credit_r != '0);
  assign send        = rsp_v_i & rsp_ready_o;

  always_ff @(posedge mc_clk_i) begin
    if (!rst_n_i) begin
      credit_r <= cnt_width_lp'(credits_p);
    end else begin
      case ({send, link_token_i})
        2'b10:   credit_r <= credit_r - 1'b1;
        2'b01:   credit_r <= credit_r + 1'b1;
        // send and token together cancel out
        default: credit_r <= credit_r;
      endcase
    end
  end

  always_ff @(posedge mc_clk_i) begin
    if (!rst_n_i) begin
      link_v_o <= 1'b0;
    end else begin
      link_v_o <= send;
    end
  end

  // link packet loaded on each send
  always_ff @(posedge mc_clk_i) begin
    if (send) begin
      link_data_o <= rsp_pkt_i;
    end
  end

endmodule

`default_nettype wire

// ==== rtl/mc_endpoint_mem.sv ====
`default_nettype none

module mc_endpoint_mem
  import core_complex_pkg::*;
  (input  wire                  mc_clk_i
  ,input  wire                  rst_n_i

  ,input  wire                  req_v_i
  ,input  wire mc_fwd_packet_s  req_pkt_i
  ,output logic                 req_yumi_o

  ,output logic                 rsp_v_o
  ,output mc_rev_packet_s       rsp_pkt_o
  ,input  wire                  rsp_ready_i
  );

  localparam int mem_els_lp = 2 ** mc_addr_width_p;

  logic [mc_data_width_p-1:0] mem_r [mem_els_lp];

  logic                       rsp_v_r;
  mc_rev_packet_s             rsp_pkt_r;

  logic                       rsp_xfer;
  logic                       is_store;
  logic                       is_load;
  logic [mc_data_width_p-1:0] store_data;
  logic [mc_reg_width_p-1:0]  load_reg_id;

  // response leaves this cycle
  assign rsp_xfer = rsp_v_r & rsp_ready_i;

  // take a new request only if the response slot frees up
  assign req_yumi_o = req_v_i & (~rsp_v_r | rsp_ready_i);

  // opcode picks how the payload word is read
  assign is_store    = req_yumi_o & (req_pkt_i.op == mc_op_store);
  assign is_load     = req_yumi_o & (req_pkt_i.op == mc_op_load);
  assign store_data  = req_pkt_i.payload.store_data;
  assign load_reg_id = req_pkt_i.payload.load_info.reg_id;

  // word memory cleared on reset so early loads return zero
  always_ff @(posedge mc_clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < mem_els_lp; i++) begin
        mem_r[i] <= '0;
      end
    end else if (is_store) begin
      mem_r[req_pkt_i.addr] <= store_data;
    end
  end

  // response valid flag
  always_ff @(posedge mc_clk_i) begin
    if (!rst_n_i) begin
      rsp_v_r <= 1'b0;
    end else if (req_yumi_o) begin
      rsp_v_r <= 1'b1;
    end else if (rsp_xfer) begin
      rsp_v_r <= 1'b0;
    end
  end

  // response payload held while ready is low
  // the load data comes straight from the registered memory read
  always_ff @(posedge mc_clk_i) begin
    if (req_yumi_o) begin
      rsp_pkt_r.op      <= req_pkt_i.op;
      rsp_pkt_r.dest_id <= req_pkt_i.src_id;
      if (is_load) begin
        rsp_pkt_r.reg_id <= load_reg_id;
        rsp_pkt_r.data   <= mem_r[req_pkt_i.addr];
      end else begin
        // store acks carry no register and no data
        rsp_pkt_r.reg_id <= '0;
        rsp_pkt_r.data   <= '0;
      end
    end
  end

  assign rsp_v_o   = rsp_v_r;
  assign rsp_pkt_o = rsp_pkt_r;

endmodule

`default_nettype wire

// ==== rtl/core_complex_top.sv ====
`default_nettype none

module core_complex_top
  import core_complex_pkg::*;
 #(parameter int rx_fifo_els_p = 4
  ,parameter int tx_credits_p  = 3
  )
  (input  wire                        mc_clk_i
  ,input  wire                        rst_n_i

  // forward link in
  ,input  wire  [mc_fwd_width_p-1:0]  mc_fwd_link_data_i
  ,input  wire                        mc_fwd_link_v_i
  ,output logic                       mc_fwd_link_token_o

  // reverse link out
  ,output logic [mc_rev_width_p-1:0]  mc_rev_link_data_o
  ,output logic                       mc_rev_link_v_o
  ,input  wire                        mc_rev_link_token_i
  );

  logic           req_v;
  mc_fwd_packet_s req_pkt;
  logic           req_yumi;

  logic           rsp_v;
  mc_rev_packet_s rsp_pkt;
  logic           rsp_ready;

  // forward link termination
  mc_link_token_rx #(
    .els_p (rx_fifo_els_p)
  ) rx_inst (
    .mc_clk_i     (mc_clk_i),
    .rst_n_i      (rst_n_i),
    .link_v_i     (mc_fwd_link_v_i),
    .link_data_i  (mc_fwd_packet_s'(mc_fwd_link_data_i)),
    .link_token_o (mc_fwd_link_token_o),
    .req_v_o      (req_v),
    .req_pkt_o    (req_pkt),
    .req_yumi_i   (req_yumi)
  );

  mc_endpoint_mem endpoint_inst (
    .mc_clk_i    (mc_clk_i),
    .rst_n_i     (rst_n_i),
    .req_v_i     (req_v),
    .req_pkt_i   (req_pkt),
    .req_yumi_o  (req_yumi),
    .rsp_v_o     (rsp_v),
    .rsp_pkt_o   (rsp_pkt),
    .rsp_ready_i (rsp_ready)
  );

  // reverse link source
  mc_link_token_tx #(
    .credits_p (tx_credits_p)
  ) tx_inst (
    .mc_clk_i     (mc_clk_i),
    .rst_n_i      (rst_n_i),
    .rsp_v_i      (rsp_v),
    .rsp_pkt_i    (rsp_pkt),
    .rsp_ready_o  (rsp_ready),
    .link_v_o     (mc_rev_link_v_o),
    .link_data_o  (mc_rev_link_data_o),
    .link_token_i (mc_rev_link_token_i)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_core_complex.sv ====
`default_nettype none

module tb_core_complex
  import core_complex_pkg::*;
  ();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int rx_fifo_els_lp  = 4;
  localparam int tx_credits_lp   = 3;
  localparam int random_pkts_lp  = 400;
  localparam int drain_limit_lp  = 2000;
  localparam int unused_width_lp = mc_data_width_p - mc_reg_width_p;

  // downstream token behavior
  localparam int tok_random_lp = 0;
  localparam int tok_prompt_lp = 1;
  localparam int tok_hold_lp   = 2;

  logic                      mc_clk;
  logic                      rst_n;
  logic [mc_fwd_width_p-1:0] fwd_data;
  logic                      fwd_v;
  logic                      fwd_token;
  logic [mc_rev_width_p-1:0] rev_data;
  logic                      rev_v;
  logic                      rev_token;

  // reference model
  logic [mc_data_width_p-1:0] model_mem [2**mc_addr_width_p];
  mc_rev_packet_s             exp_q [$];

  int fwd_credit;
  int pkts_sent;
  int fwd_tokens;
  int rev_valids;
  int rev_pending;
  int tokens_returned;
  int send_pct;
  int tok_mode;
  int sweep_left;
  bit send_on;
  bit prev_rev_v;
  bit b2b_seen;
  int mismatch_errs;
  int protocol_errs;
  int timeout_errs;

  initial begin
    mc_clk = 1'b0;
    forever begin
      #20 mc_clk = ~mc_clk;
    end
  end

  core_complex_top #(
    .rx_fifo_els_p (rx_fifo_els_lp),
    .tx_credits_p  (tx_credits_lp)
  ) core_complex_top_inst (
    .mc_clk_i            (mc_clk),
    .rst_n_i             (rst_n),
    .mc_fwd_link_data_i  (fwd_data),
    .mc_fwd_link_v_i     (fwd_v),
    .mc_fwd_link_token_o (fwd_token),
    .mc_rev_link_data_o  (rev_data),
    .mc_rev_link_v_o     (rev_v),
    .mc_rev_link_token_i (rev_token)
  );

  task automatic check_eq(input logic [63:0] got, input logic [63:0] exp, input string what);
    if (got !== exp) begin
      mismatch_errs++;
      $display("ERR %0d ns: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // next request with the model memory updated in request order
  task automatic make_packet(output mc_fwd_packet_s pkt, output mc_rev_packet_s exp);
    logic [mc_addr_width_p-1:0] addr;
    addr = mc_addr_width_p'($urandom);
    pkt.src_id = mc_src_width_p'($urandom);
    if (sweep_left > 0) begin
      addr = mc_addr_width_p'(2**mc_addr_width_p - sweep_left);
      pkt.op = mc_op_load;
      sweep_left--;
    end else if ($urandom % 2 == 1) begin
      pkt.op = mc_op_store;
    end else begin
      pkt.op = mc_op_load;
    end
    pkt.addr    = addr;
    exp.op      = pkt.op;
    exp.dest_id = pkt.src_id;
    if (pkt.op == mc_op_store) begin
      pkt.payload.store_data = $urandom;
      model_mem[addr] = pkt.payload.store_data;
      exp.reg_id = '0;
      exp.data   = '0;
    end else begin
      pkt.payload.load_info.reg_id = mc_reg_width_p'($urandom);
      pkt.payload.load_info.unused = unused_width_lp'($urandom);
      exp.reg_id = pkt.payload.load_info.reg_id;
      exp.data   = model_mem[addr];
    end
  endtask

  // one clock of sampling outputs and then driving both link sides
  task automatic run_cycle();
    mc_fwd_packet_s pkt;
    mc_rev_packet_s new_exp;
    mc_rev_packet_s want;
    mc_rev_packet_s got;
    @(negedge mc_clk);
    if (fwd_token) begin
      fwd_tokens++;
      fwd_credit++;
    end
    if (fwd_credit > rx_fifo_els_lp || fwd_tokens > pkts_sent) begin
      protocol_errs++;
      $display("forward link returned more tokens than packets sent at %0d ns", $time);
    end
    if (rev_v) begin
      rev_valids++;
      rev_pending++;
      got = rev_data;
      if (exp_q.size() == 0) begin
        protocol_errs++;
        $display("return packet at %0d ns with no request outstanding", $time);
      end else begin
        want = exp_q.pop_front();
        check_eq(64'(got.op), 64'(want.op), "return op");
        check_eq(64'(got.reg_id), 64'(want.reg_id), "return reg_id");
        check_eq(64'(got.dest_id), 64'(want.dest_id), "return dest_id");
        check_eq(64'(got.data), 64'(want.data), "return data");
      end
    end
    if (rev_valids > tokens_returned + tx_credits_lp) begin
      protocol_errs++;
      $display("reverse link sent without a credit at %0d ns", $time);
    end
    if (rev_v && prev_rev_v) begin
      b2b_seen = 1'b1;
    end
    prev_rev_v = rev_v;

    // downstream only returns credits it has used
    rev_token = 1'b0;
    if (tok_mode != tok_hold_lp && rev_pending > 0 &&
        (tok_mode == tok_prompt_lp || $urandom % 4 == 0)) begin
      rev_token = 1'b1;
      rev_pending--;
      tokens_returned++;
    end

    fwd_v = 1'b0;
    if (send_on && fwd_credit > 0 && ($urandom % 100) < send_pct) begin
      make_packet(pkt, new_exp);
      exp_q.push_back(new_exp);
      fwd_data = pkt;
      fwd_v    = 1'b1;
      fwd_credit--;
      pkts_sent++;
    end
  endtask

  task automatic drain(input string phase);
    int guard;
    guard   = 0;
    send_on = 1'b0;
    while ((exp_q.size() != 0 || rev_pending != 0 || fwd_credit != rx_fifo_els_lp) &&
           guard < drain_limit_lp) begin
      run_cycle();
      guard++;
    end
    if (guard >= drain_limit_lp) begin
      timeout_errs++;
      $display("timeout: %s did not drain within %0d cycles", phase, drain_limit_lp);
    end
  endtask

  initial begin
    int guard;
    int start;
    int fwd_snap;
    int rev_snap;
    void'($urandom(91));
    rst_n     = 1'b0;
    fwd_v     = 1'b0;
    fwd_data  = '0;
    rev_token = 1'b0;
    fwd_credit      = rx_fifo_els_lp;
    pkts_sent       = 0;
    fwd_tokens      = 0;
    rev_valids      = 0;
    rev_pending     = 0;
    tokens_returned = 0;
    send_on    = 1'b0;
    send_pct   = 0;
    tok_mode   = tok_prompt_lp;
    sweep_left = 0;
    prev_rev_v = 1'b0;
    b2b_seen   = 1'b0;
    mismatch_errs = 0;
    protocol_errs = 0;
    timeout_errs  = 0;
    for (int i = 0; i < 2**mc_addr_width_p; i++) begin
      model_mem[i] = '0;
    end

    repeat (10) @(posedge mc_clk);
    @(negedge mc_clk);
    rst_n = 1'b1;

    // quiet link after reset
    repeat (8) begin
      run_cycle();
      check_eq(64'(rev_v), 64'd0, "reverse valid while idle");
      check_eq(64'(fwd_token), 64'd0, "forward token while idle");
    end

    // every address reads zero before any store
    sweep_left = 2**mc_addr_width_p;
    send_on    = 1'b1;
    send_pct   = 100;
    guard      = 0;
    while (sweep_left > 0 && guard < 500) begin
      run_cycle();
      guard++;
    end
    if (sweep_left > 0) begin
      timeout_errs++;
      $display("timeout: load sweep could not send all requests");
    end
    drain("load sweep");

    // random loads and stores with random token delay
    start    = pkts_sent;
    tok_mode = tok_random_lp;
    send_pct = 70;
    send_on  = 1'b1;
    guard    = 0;
    while (pkts_sent - start < random_pkts_lp && guard < 20000) begin
      run_cycle();
      guard++;
    end
    if (pkts_sent - start < random_pkts_lp) begin
      timeout_errs++;
      $display("timeout: only %0d random packets were sent", pkts_sent - start);
    end
    drain("random traffic");

    // reverse tokens withheld while the pipeline fills up
    tok_mode = tok_hold_lp;
    send_pct = 100;
    send_on  = 1'b1;
    fwd_snap = 0;
    rev_snap = 0;
    for (int i = 0; i < 50; i++) begin
      run_cycle();
      if (i == 29) begin
        fwd_snap = fwd_tokens;
        rev_snap = rev_valids;
      end
    end
    check_eq(64'(fwd_tokens), 64'(fwd_snap), "forward tokens while stalled");
    check_eq(64'(rev_valids), 64'(rev_snap), "reverse valids while stalled");
    tok_mode = tok_random_lp;
    drain("back-pressure release");

    // prompt tokens on both sides
    b2b_seen = 1'b0;
    tok_mode = tok_prompt_lp;
    send_pct = 100;
    send_on  = 1'b1;
    repeat (80) run_cycle();
    drain("throughput run");
    check_eq(64'(b2b_seen), 64'd1, "back to back reverse packets");

    check_eq(64'(fwd_tokens), 64'(pkts_sent), "forward tokens after run");
    check_eq(64'(rev_valids), 64'(pkts_sent), "return packets after run");
    check_eq(64'(exp_q.size()), 64'd0, "expected packets left over");

    $display("errors: %0d mismatches, %0d protocol, %0d timeouts over %0d packets",
             mismatch_errs, protocol_errs, timeout_errs, pkts_sent);
    if (mismatch_errs + protocol_errs + timeout_errs == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src.f ====
rtl/core_complex_pkg.sv
rtl/mc_link_token_rx.sv
rtl/mc_link_token_tx.sv
rtl/mc_endpoint_mem.sv
rtl/core_complex_top.sv
testbench/tb_core_complex.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the core complex testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f src.f --top-module tb_core_complex \
  --Mdir "$build_dir" -o tb_core_complex
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

"./$build_dir/tb_core_complex" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qF '** FAIL **' "$log_file"; then
  echo "simulation reported a failure, see $log_file"
  exit 1
fi

echo "simulation finished without failure"
exit 0
